// File: hw/sys_cmd_pkg.sv
//////////////////////////////
// Host command package
// Command codes, host word widths and
// configuration bit positions
//////////////////////////////

`default_nettype none

package sys_cmd_pkg;

	// Host word channel
	localparam int IO_DW = 16;
	localparam int CMD_W = 8;

	// Command codes, taken from the first word after select
	localparam logic [CMD_W-1:0] CMD_CFG = 8'h01;
	localparam logic [CMD_W-1:0] CMD_LED = 8'h25;
	localparam logic [CMD_W-1:0] CMD_VOL = 8'h26;

	// Configuration word
	localparam int CFG_CSYNC_BIT = 3;

	// LED panel
	localparam int LED_W = 8;

	// Default pattern positions
	localparam int LED_POWER_POS = 4;
	localparam int LED_DISK_POS  = 2;
	localparam int LED_USER_POS  = 0;

endpackage

`default_nettype wire

// File: hw/av_pkg.sv
//////////////////////////////
// Audio and video package
// Sample types, cross-feed modes and
// sync counter width
//////////////////////////////

`default_nettype none

package av_pkg;

	// Audio samples
	localparam int SAMPLE_W = 16;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Attenuation, top bit mutes
	localparam int ATT_W = 5;

	// Cross-feed amount between left and right
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

	// Phase and line length counters
	localparam int SYNC_CNT_W = 16;

endpackage

`default_nettype wire

// File: hw/hps_cmd_decoder.sv
//////////////////////////////
// Host command decoder
// Strobe/ack handshake, command latch,
// settings registers and LED panel
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hps_cmd_decoder
	import sys_cmd_pkg::*;
	import av_pkg::*;
(
	input  wire              clk,
	input  wire              resetd,
	input  wire              i_io_clk,
	input  wire              i_io_uio,
	input  wire  [IO_DW-1:0] i_io_din,
	input  wire        [2:0] i_led_status,
	output logic             o_io_ack,
	output logic [ATT_W-1:0] o_vol_att,
	output logic             o_csync_en,
	output logic [LED_W-1:0] o_led
);

	logic             rack;
	logic             io_strobe;
	logic             has_cmd;
	logic [CMD_W-1:0] cmd;
	logic [LED_W-1:0] led_overtake;
	logic [LED_W-1:0] led_state;
	logic [LED_W-1:0] led_dflt;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// One cycle pulse on each rise of the host clock
	assign io_strobe = i_io_clk & ~rack;

	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	//////////////////////////////
	// Command and data words
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= '0;
			o_csync_en   <= 1'b0;
			o_vol_att    <= '0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!i_io_uio) begin
			// Deselected, drop whatever was pending
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_io_din[CMD_W-1:0];
			end else begin
				case (cmd)
					CMD_CFG: o_csync_en <= i_io_din[CFG_CSYNC_BIT];
					CMD_LED: {led_overtake, led_state} <= i_io_din;
					CMD_VOL: o_vol_att <= i_io_din[ATT_W-1:0];
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// LED panel
	//////////////////////////////

	// Status bits are {power, disk, user}
	always_comb begin
		led_dflt                = '0;
		led_dflt[LED_POWER_POS] = i_led_status[2];
		led_dflt[LED_DISK_POS]  = i_led_status[1];
		led_dflt[LED_USER_POS]  = i_led_status[0];
	end

	// Host state where overtaken, default pattern elsewhere
	assign o_led = (led_overtake & led_state) | (~led_overtake & led_dflt);

endmodule

`default_nettype wire

// File: hw/audio_mixer.sv
//////////////////////////////
// Audio mixer, one channel
// Deglitch, Linux sum, cross-feed,
// attenuation and clamp
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_mixer
	import av_pkg::*;
(
	input  wire              clk,
	input  wire              resetd,
	input  sample_t          i_core,
	input  sample_t          i_alsa,
	input  wire              i_signed,
	input  mix_mode_t        i_mix,
	input  wire  [ATT_W-1:0] i_att,
	input  sample_t          i_pre,
	output sample_t          o_pre,
	output sample_t          o_out
);

	// One extra bit of headroom through the mix
	localparam int MIX_W = SAMPLE_W + 1;

	sample_t                  core_d1;
	sample_t                  core_d2;
	sample_t                  core_d3;
	sample_t                  core_s;
	logic signed [MIX_W-1:0]  a_ext;
	logic signed [MIX_W-1:0]  a_sum;
	logic signed [MIX_W-1:0]  a_mix;
	logic signed [MIX_W-1:0]  a_att;

	//////////////////////////////
	// Deglitch
	//////////////////////////////

	// Core sample only taken once two delayed copies agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1 <= '0;
			core_d2 <= '0;
			core_d3 <= '0;
			core_s  <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d2 == core_d3)
				core_s <= core_d2;
		end
	end

	//////////////////////////////
	// Mix pipeline
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a_ext <= '0;
			a_sum <= '0;
			a_mix <= '0;
			a_att <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned audio is halved to fit the signed range
			a_ext <= i_signed ? {core_s[SAMPLE_W-1], core_s}
			                  : {2'b00, core_s[SAMPLE_W-1:1]};
			a_sum <= a_ext + $signed({i_alsa[SAMPLE_W-1], i_alsa});

			// Halved sum goes to the other channel
			o_pre <= a_sum[MIX_W-1:1];

			case (i_mix)
				MIX_NONE: a_mix <= a_sum;
				MIX_25:   a_mix <= a_sum - (a_sum >>> 3) + (i_pre >>> 2);
				MIX_50:   a_mix <= a_sum - (a_sum >>> 2) + (i_pre >>> 1);
				MIX_MONO: a_mix <= (a_sum >>> 1) + i_pre;
				default:  a_mix <= a_sum;
			endcase

			if (i_att[ATT_W-1])
				a_att <= '0;
			else
				a_att <= a_mix >>> i_att[ATT_W-2:0];

			// Saturate when the two top bits differ
			if (a_att[MIX_W-1] ^ a_att[MIX_W-2])
				o_out <= {a_att[MIX_W-1], {(SAMPLE_W-1){a_att[MIX_W-2]}}};
			else
				o_out <= a_att[SAMPLE_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/sync_polarity.sv
//////////////////////////////
// Sync polarity normaliser
// Short phase of the sync always shows high
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sync_polarity
	import av_pkg::*;
(
	input  wire  clk,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] len_hi;
	logic [SYNC_CNT_W-1:0] len_lo;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			pol    <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Phase length captured at each edge
			if (~s2 & s1)
				len_lo <= cnt;
			if (s2 & ~s1)
				len_hi <= cnt;

			if (s2 != s1)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;

			pol <= len_hi > len_lo;
		end
	end

endmodule

`default_nettype wire

// File: hw/csync_gen.sv
//////////////////////////////
// Composite sync generator
// Serrated csync from normalised
// hsync and vsync, with output select
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csync_gen
	import av_pkg::*;
(
	input  wire  clk,
	input  wire  resetd,
	input  wire  i_hs,
	input  wire  i_vs,
	input  wire  i_csync_en,
	output logic o_sync_h
);

	logic                  hs_prev;
	logic                  cs_hs;
	logic                  cs_vs;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;

	// Plain hsync passes straight through when csync is off
	assign o_sync_h = i_csync_en ? (cs_vs ^ cs_hs) : i_hs;

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_prev  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_prev <= i_hs;
			cs_vs   <= i_vs;
			h_cnt   <= h_cnt + 1'b1;

			// Measure each phase of the line
			if (hs_prev ^ i_hs) begin
				h_cnt <= '0;
				if (i_hs)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end

			// During vsync the pulse moves one hsync width earlier
			if (!i_vs)
				cs_hs <= i_hs;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;
			else if (~hs_prev & i_hs)
				cs_hs <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/sys_core_top.sv
//////////////////////////////
// System core top level
// Host commands, LEDs, stereo mixer
// and video sync path
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sys_core_top
	import sys_cmd_pkg::*;
	import av_pkg::*;
(
	input  wire              clk,
	input  wire              resetd,

	// Host command port
	input  wire              i_io_clk,
	input  wire              i_io_uio,
	input  wire  [IO_DW-1:0] i_io_din,
	output logic             o_io_ack,

	// LED panel
	input  wire        [2:0] i_led_status,
	output logic [LED_W-1:0] o_led,

	// Audio
	input  sample_t          i_core_l,
	input  sample_t          i_core_r,
	input  sample_t          i_alsa_l,
	input  sample_t          i_alsa_r,
	input  wire              i_audio_signed,
	input  mix_mode_t        i_mix,
	output sample_t          o_audio_l,
	output sample_t          o_audio_r,

	// Video sync
	input  wire              i_hs,
	input  wire              i_vs,
	output logic             o_sync_h,
	output logic             o_vs
);

	logic [ATT_W-1:0] vol_att;
	logic             csync_en;
	sample_t          pre_l;
	sample_t          pre_r;
	logic             hs_norm;

	hps_cmd_decoder hps_cmd_decoder_inst (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_clk     (i_io_clk),
		.i_io_uio     (i_io_uio),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_io_ack     (o_io_ack),
		.o_vol_att    (vol_att),
		.o_csync_en   (csync_en),
		.o_led        (o_led)
	);

	//////////////////////////////
	// Audio, pre sums cross over
	//////////////////////////////

	audio_mixer audio_mixer_l_inst (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_l),
		.i_alsa   (i_alsa_l),
		.i_signed (i_audio_signed),
		.i_mix    (i_mix),
		.i_att    (vol_att),
		.i_pre    (pre_r),
		.o_pre    (pre_l),
		.o_out    (o_audio_l)
	);

	audio_mixer audio_mixer_r_inst (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_r),
		.i_alsa   (i_alsa_r),
		.i_signed (i_audio_signed),
		.i_mix    (i_mix),
		.i_att    (vol_att),
		.i_pre    (pre_l),
		.o_pre    (pre_r),
		.o_out    (o_audio_r)
	);

	//////////////////////////////
	// Video sync
	//////////////////////////////

	sync_polarity sync_polarity_h_inst (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_hs),
		.o_sync (hs_norm)
	);

	sync_polarity sync_polarity_v_inst (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_vs),
		.o_sync (o_vs)
	);

	csync_gen csync_gen_inst (
		.clk        (clk),
		.resetd     (resetd),
		.i_hs       (hs_norm),
		.i_vs       (o_vs),
		.i_csync_en (csync_en),
		.o_sync_h   (o_sync_h)
	);

endmodule

`default_nettype wire

// File: include/tb_checks.svh
//////////////////////////////
// Testbench helpers
// Value check, host word writes and
// reference models for LEDs and audio
//////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare one DUT output against its expected value
task automatic check_value(input string name, input int got, input int expected);
	if (got !== expected) begin
		$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, expected);
		errors_total = errors_total + 1;
		test_errors  = test_errors + 1;
	end
	checks_total = checks_total + 1;
	test_checks  = test_checks + 1;
endtask

// Wait on falling edges until the acknowledge follows the host clock
task automatic wait_ack(input logic level);
	do
		@(negedge clk);
	while (io_ack !== level);
endtask

// One word per rising edge of the host clock
task automatic send_word(input logic [IO_DW-1:0] word);
	@(posedge clk);
	io_din <= word;
	io_clk <= 1'b1;
	wait_ack(1'b1);
	@(posedge clk);
	io_clk <= 1'b0;
	wait_ack(1'b0);
endtask

// Command word, then a single data word, then deselect
task automatic host_write(input logic [CMD_W-1:0] cmd_code, input logic [IO_DW-1:0] data);
	@(posedge clk);
	io_uio <= 1'b1;
	send_word({{(IO_DW-CMD_W){1'b0}}, cmd_code});
	send_word(data);
	@(posedge clk);
	io_uio <= 1'b0;
endtask

// Status bits are {power, disk, user}
function automatic logic [LED_W-1:0] led_model(input logic [2:0] status,
		input logic [LED_W-1:0] overtake, input logic [LED_W-1:0] state);
	logic [LED_W-1:0] leds;
	for (int i = 0; i < LED_W; i++) begin
		if (overtake[i])
			leds[i] = state[i];
		else if (i == LED_POWER_POS)
			leds[i] = status[2];
		else if (i == LED_DISK_POS)
			leds[i] = status[1];
		else if (i == LED_USER_POS)
			leds[i] = status[0];
		else
			leds[i] = 1'b0;
	end
	return leds;
endfunction

// Division rounding toward minus infinity
function automatic int floor_div(input int value, input int divisor);
	int quot;
	quot = value / divisor;
	if ((value % divisor != 0) && (value < 0))
		quot = quot - 1;
	return quot;
endfunction

// Core plus Linux audio ahead of the cross-feed
function automatic int sum_model(input logic [15:0] core, input logic [15:0] alsa,
		input logic sgn);
	int widened;
	if (sgn)
		widened = int'($signed(core));
	else
		widened = int'(core >> 1);
	return widened + int'($signed(alsa));
endfunction

// Cross-feed, volume and clamp for one channel
function automatic int mix_model(input int sum, input int pre_other,
		input logic [1:0] mode, input logic [ATT_W-1:0] att);
	int mixed;
	int scaled;
	case (mode)
		MIX_NONE: mixed = sum;
		MIX_25:   mixed = sum - floor_div(sum, 8) + floor_div(pre_other, 4);
		MIX_50:   mixed = sum - floor_div(sum, 4) + floor_div(pre_other, 2);
		default:  mixed = floor_div(sum, 2) + pre_other;
	endcase
	if (att[ATT_W-1])
		scaled = 0;
	else
		scaled = floor_div(mixed, 1 << att[ATT_W-2:0]);
	if (scaled > 32767)
		return 32767;
	if (scaled < -32768)
		return -32768;
	return scaled;
endfunction

`endif

// File: tb/tb_sys_core.sv
//////////////////////////////
// System core testbench
// Host commands, LEDs, audio mix and
// sync path against a local model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_sys_core
	import sys_cmd_pkg::*;
	import av_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int FRAME_LINES    = 16;
	localparam int SEED           = 35085;

	logic             clk;
	logic             resetd;
	logic             io_clk;
	logic             io_uio;
	logic [IO_DW-1:0] io_din;
	logic             io_ack;
	logic       [2:0] led_status;
	logic [LED_W-1:0] led;
	sample_t          core_l;
	sample_t          core_r;
	sample_t          alsa_l;
	sample_t          alsa_r;
	logic             audio_signed;
	mix_mode_t        mix;
	sample_t          audio_l;
	sample_t          audio_r;
	logic             hs;
	logic             vs;
	logic             sync_h;
	logic             vs_out;

	int               checks_total;
	int               errors_total;
	int               test_checks;
	int               test_errors;
	int               tests_done;
	int unsigned      cycle_count;

	// Video timing generator state
	bit               sync_run;
	int               line_len;
	int               hs_width;
	int               vs_lines;
	int               h_pos;
	int               line_idx;

	`include "tb_checks.svh"

	sys_core_top sys_core_top_inst (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_clk       (io_clk),
		.i_io_uio       (io_uio),
		.i_io_din       (io_din),
		.o_io_ack       (io_ack),
		.i_led_status   (led_status),
		.o_led          (led),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_alsa_l       (alsa_l),
		.i_alsa_r       (alsa_r),
		.i_audio_signed (audio_signed),
		.i_mix          (mix),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r),
		.i_hs           (hs),
		.i_vs           (vs),
		.o_sync_h       (sync_h),
		.o_vs           (vs_out)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Sync generator
	//////////////////////////////

	// Active low pulses, vsync spans whole lines
	always @(posedge clk) begin
		if (sync_run) begin
			hs <= !(h_pos < hs_width);
			vs <= !(line_idx < vs_lines);
			if (h_pos == line_len - 1) begin
				h_pos    <= 0;
				line_idx <= (line_idx == FRAME_LINES - 1) ? 0 : line_idx + 1;
			end else begin
				h_pos <= h_pos + 1;
			end
		end
	end

	task automatic end_test(input string title);
		tests_done = tests_done + 1;
		$display("test %0d %s: %0d checks, %0d errors", tests_done, title,
			test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int unsigned      seed_dummy;
		int               sum_l;
		int               sum_r;
		int               frame_len;
		int               vs_run;
		logic             hs_last;
		logic [IO_DW-1:0] word;
		logic [ATT_W-1:0] att;

		seed_dummy   = $urandom(SEED);
		clk          = 1'b0;
		resetd       = 1'b1;
		io_clk       = 1'b0;
		io_uio       = 1'b0;
		io_din       = '0;
		led_status   = '0;
		core_l       = '0;
		core_r       = '0;
		alsa_l       = '0;
		alsa_r       = '0;
		audio_signed = 1'b0;
		mix          = MIX_NONE;
		hs           = 1'b1;
		vs           = 1'b1;
		sync_run     = 1'b0;
		h_pos        = 0;
		line_idx     = 0;
		line_len     = 48;
		hs_width     = 4;
		vs_lines     = 2;
		checks_total = 0;
		errors_total = 0;
		test_checks  = 0;
		test_errors  = 0;
		tests_done   = 0;
		cycle_count  = 0;

		repeat (2) @(posedge clk);
		resetd <= 1'b0;

		// Default LED pattern straight after reset
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			led_status <= 3'($urandom);
			@(negedge clk);
			check_value("o_io_ack", io_ack, 0);
			check_value("o_led", led, led_model(led_status, '0, '0));
		end
		end_test("led default");

		for (int i = 0; i < 20; i++) begin
			word = IO_DW'($urandom);
			@(posedge clk);
			led_status <= 3'($urandom);
			host_write(CMD_LED, word);
			repeat (2) @(posedge clk);
			@(negedge clk);
			check_value("o_led", led, led_model(led_status, word[15:8], word[7:0]));
		end
		end_test("led overtake");

		// Audio with every fifth volume muted
		mix <= MIX_NONE;
		for (int i = 0; i < 40; i++) begin
			att = (i % 5 == 4) ? ATT_W'(16 + $urandom_range(0, 15)) : ATT_W'($urandom_range(0, 7));
			host_write(CMD_VOL, IO_DW'(att));
			@(posedge clk);
			core_l       <= 16'($urandom);
			core_r       <= 16'($urandom);
			alsa_l       <= 16'($urandom);
			alsa_r       <= 16'($urandom);
			audio_signed <= 1'($urandom);
			repeat (16) @(posedge clk);
			@(negedge clk);
			sum_l = sum_model(core_l, alsa_l, audio_signed);
			sum_r = sum_model(core_r, alsa_r, audio_signed);
			check_value("o_audio_l", audio_l, mix_model(sum_l, sum_r >>> 1, MIX_NONE, att));
			check_value("o_audio_r", audio_r, mix_model(sum_r, sum_l >>> 1, MIX_NONE, att));
		end
		end_test("audio plain");

		for (int m = 1; m < 4; m++) begin
			att = ATT_W'($urandom_range(0, 2));
			host_write(CMD_VOL, IO_DW'(att));
			for (int i = 0; i < 20; i++) begin
				@(posedge clk);
				mix          <= mix_mode_t'(m);
				core_l       <= 16'($urandom);
				core_r       <= 16'($urandom);
				alsa_l       <= 16'($urandom);
				alsa_r       <= 16'($urandom);
				audio_signed <= 1'($urandom);
				repeat (16) @(posedge clk);
				@(negedge clk);
				sum_l = sum_model(core_l, alsa_l, audio_signed);
				sum_r = sum_model(core_r, alsa_r, audio_signed);
				check_value("o_audio_l", audio_l, mix_model(sum_l, sum_r >>> 1, 2'(m), att));
				check_value("o_audio_r", audio_r, mix_model(sum_r, sum_l >>> 1, 2'(m), att));
			end
		end
		end_test("audio cross-feed");

		// Polarity settles within three frames
		host_write(CMD_CFG, '0);
		@(negedge clk);
		line_len  = 40 + $urandom_range(0, 24);
		hs_width  = 3 + $urandom_range(0, 5);
		vs_lines  = 2 + $urandom_range(0, 2);
		frame_len = line_len * FRAME_LINES;
		@(posedge clk);
		sync_run <= 1'b1;
		repeat (3 * frame_len) @(posedge clk);
		repeat (frame_len) begin
			@(negedge clk);
			check_value("o_vs", vs_out, !vs);
			check_value("o_sync_h", sync_h, !hs);
		end
		end_test("sync polarity");

		host_write(CMD_CFG, IO_DW'(1) << CFG_CSYNC_BIT);
		@(negedge clk);
		hs_last = hs;
		vs_run  = 0;
		repeat (2 * frame_len) begin
			@(negedge clk);
			if (vs)
				vs_run = vs_run + 1;
			else
				vs_run = 0;
			// Only lines well clear of vsync
			if (vs_run > line_len)
				check_value("o_sync_h", sync_h, !hs_last);
			hs_last = hs;
		end
		end_test("composite sync");

		$display("tests %0d, checks %0d, errors %0d", tests_done, checks_total, errors_total);
		if (errors_total == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/sys_cmd_pkg.sv
hw/av_pkg.sv
hw/hps_cmd_decoder.sv
hw/audio_mixer.sv
hw/sync_polarity.sv
hw/csync_gen.sv
hw/sys_core_top.sv
tb/tb_sys_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into sim.log, then search the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sys_core -f all.f -o tb_sys_core_sim \
	&& ./obj_dir/tb_sys_core_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation finished without failure"; exit 0; }
